// File: testbench/freq_vectors.txt
0 0
1 500
2 250
5 100
7 71
3 167
25 20
50 10

// File: project.f
rtl/freq_pkg.sv
rtl/bcd_digit_cell.sv
rtl/edge_gate_counter.sv
rtl/dabble_controller.sv
rtl/display_scanner.sv
rtl/freq_display_top.sv
testbench/freq_display_tb.sv

// File: testbench/freq_display_tb.sv
// ======================================================================
// testbench for the frequency counter; plays each square wave of the
// vector file into the DUT, checks the readings, their timing and the
// multiplexed display, with a watchdog bounding the run
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module freq_display_tb;
	logic               clock;
	logic               reset;
	logic               signal_in;
	freq_pkg::segment_t segment;
	freq_pkg::anode_t   anode;
	freq_pkg::reading_t reading;
	logic               reading_valid;

	// stimulus
	int half_period;
	int phase;
	int vec_half[$];
	int vec_count[$];
	bit vectors_loaded;

	int reading_errors;
	int timing_errors;
	int display_errors;

	// monitor state, cycles counted from reset release
	int                 cycle;
	int                 last_valid_cycle;
	bit                 seen_reading;
	freq_pkg::reading_t shown_reading;

	freq_display_top freq_display_top_i (
		.clock(clock),
		.reset(reset),
		.signal_in(signal_in),
		.segment(segment),
		.anode(anode),
		.reading(reading),
		.reading_valid(reading_valid)
	);

	always #50 clock = ~clock;

	// integer to packed bcd, digit 0 low
	function automatic freq_pkg::reading_t to_bcd(input int value);
		freq_pkg::reading_t r;
		int rest;
		r = '0;
		rest = value;
		for (int i = 0; i < freq_pkg::NUM_DIGITS; i++) begin
			r[i*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return r;
	endfunction

	// common seven segment shapes, bits g..a
	function automatic logic [6:0] glyph_of(input freq_pkg::bcd_digit_t d);
		case (d)
			4'd0: return 7'b0111111;
			4'd1: return 7'b0000110;
			4'd2: return 7'b1011011;
			4'd3: return 7'b1001111;
			4'd4: return 7'b1100110;
			4'd5: return 7'b1101101;
			4'd6: return 7'b1111101;
			4'd7: return 7'b0000111;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	// index of the single lit anode, -1 if not one hot
	function automatic int lit_anode(input freq_pkg::anode_t a);
		int index;
		int lit;
		index = -1;
		lit = 0;
		for (int i = 0; i < freq_pkg::NUM_DIGITS; i++) begin
			if (a[i] === 1'b1) begin
				index = i;
				lit++;
			end
		end
		return (lit == 1) ? index : -1;
	endfunction

	task automatic wait_reading(output freq_pkg::reading_t r);
		do @(negedge clock); while (reading_valid !== 1'b1);
		r = reading;
	endtask

	// every nibble of a reading is a decimal digit
	task automatic check_nibbles(input int v, input freq_pkg::reading_t r);
		for (int i = 0; i < freq_pkg::NUM_DIGITS; i++) begin
			if (r[i*4 +: 4] > 4'd9) begin
				$display("ERROR digits h=%0d: expected nibbles up to 9, actual %h",
					vec_half[v], r);
				reading_errors++;
			end
		end
	endtask

	// accepts the nominal count +/- 1, exact for a held input
	task automatic check_reading(input int v, input freq_pkg::reading_t r);
		int low;
		int high;
		bit matched;
		check_nibbles(v, r);
		low = (vec_half[v] == 0 || vec_count[v] == 0) ? vec_count[v] : vec_count[v] - 1;
		high = (vec_half[v] == 0) ? vec_count[v] : vec_count[v] + 1;
		matched = 1'b0;
		for (int n = low; n <= high; n++) begin
			if (r === to_bcd(n)) begin
				matched = 1'b1;
			end
		end
		if (!matched) begin
			$display("ERROR count h=%0d: expected %h (+/-%0d), actual %h", vec_half[v],
				to_bcd(vec_count[v]), high - vec_count[v], r);
			reading_errors++;
		end
	endtask

	// square wave, toggled every half_period clocks, low when zero
	always @(posedge clock) begin
		#5;
		if (half_period == 0) begin
			signal_in = 1'b0;
			phase = 0;
		end else if (phase >= half_period - 1) begin
			signal_in = ~signal_in;
			phase = 0;
		end else begin
			phase = phase + 1;
		end
	end

	// reset values, reading timing and display scan
	always @(negedge clock) begin
		int k;
		freq_pkg::segment_t expected_segment;
		if (reset) begin
			cycle = 0;
			if (anode !== '0 || reading_valid !== 1'b0 || reading !== '0) begin
				$display("ERROR reset: expected anode 0 valid 0 reading 0, actual %h %b %h",
					anode, reading_valid, reading);
				display_errors++;
			end
		end else begin
			cycle = cycle + 1;
			if (reading_valid === 1'b1) begin
				if (!seen_reading && cycle > freq_pkg::GATE_CYCLES + 40) begin
					$display("ERROR first_reading: expected within %0d cycles, actual %0d",
						freq_pkg::GATE_CYCLES + 40, cycle);
					timing_errors++;
				end
				if (seen_reading && cycle - last_valid_cycle != freq_pkg::GATE_CYCLES) begin
					$display("ERROR interval: expected %0d, actual %0d",
						freq_pkg::GATE_CYCLES, cycle - last_valid_cycle);
					timing_errors++;
				end
				seen_reading = 1'b1;
				last_valid_cycle = cycle;
				shown_reading = reading;
			end else if (!seen_reading && reading !== '0) begin
				$display("ERROR idle_reading: expected 0, actual %h", reading);
				reading_errors++;
			end
			// first anode lights one clock after release
			if (cycle >= 2) begin
				k = lit_anode(anode);
				if (k < 0) begin
					$display("anode is not one hot during the scan: %b", anode);
					display_errors++;
				end else begin
					expected_segment = {glyph_of(shown_reading[k*4 +: 4]),
						k == freq_pkg::DP_DIGIT};
					if (segment !== expected_segment) begin
						$display("ERROR segment digit %0d: expected %h, actual %h", k,
							expected_segment, segment);
						display_errors++;
					end
				end
			end
		end
	end

	initial begin
		int fd;
		int code;
		int h;
		int n;
		freq_pkg::reading_t r;
		clock = 1'b0;
		reset = 1'b1;
		signal_in = 1'b0;
		half_period = 0;
		phase = 0;
		vectors_loaded = 1'b0;
		reading_errors = 0;
		timing_errors = 0;
		display_errors = 0;
		cycle = 0;
		last_valid_cycle = 0;
		seen_reading = 1'b0;
		shown_reading = '0;
		fd = $fopen("testbench/freq_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file testbench/freq_vectors.txt");
			$display("Test FAILED");
			$finish;
		end
		code = $fscanf(fd, "%d %d\n", h, n);
		while (code == 2) begin
			vec_half.push_back(h);
			vec_count.push_back(n);
			code = $fscanf(fd, "%d %d\n", h, n);
		end
		$fclose(fd);
		if (vec_half.size() == 0) begin
			$display("the vector file holds no tests");
			reading_errors++;
		end
		vectors_loaded = 1'b1;
		repeat (3) @(posedge clock);
		#5 reset = 1'b0;
		foreach (vec_half[v]) begin
			@(negedge clock);
			half_period = vec_half[v];
			// this gate straddles the change
			wait_reading(r);
			check_nibbles(v, r);
			repeat (2) begin
				wait_reading(r);
				check_reading(v, r);
			end
		end
		$display("errors: %0d reading, %0d timing, %0d display", reading_errors,
			timing_errors, display_errors);
		if (reading_errors + timing_errors + display_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// four gates per test plus margin
	initial begin
		longint limit_ns;
		wait (vectors_loaded);
		limit_ns = (longint'(vec_half.size()) * 4 * freq_pkg::GATE_CYCLES + 2000) * 100;
		#(limit_ns);
		$display("watchdog expired before all readings arrived");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/freq_display_top.sv
// ======================================================================
// frequency counter top level; gate counter, dabble controller, chain
// of bcd digit cells and the display scanner on one system clock
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module freq_display_top (
	input  logic               clock,
	input  logic               reset,
	input  logic               signal_in,
	output freq_pkg::segment_t segment,
	output freq_pkg::anode_t   anode,
	output freq_pkg::reading_t reading,
	output logic               reading_valid
);
	logic                              count_valid;
	freq_pkg::count_t                  count;
	logic                              credit_return;
	logic                              cell_clear;
	logic                              cell_shift;
	logic                              serial_bit;
	logic                              convert_done;
	// carry chain through the digits, top bit is overflow
	logic [freq_pkg::NUM_DIGITS:0]     carry;
	freq_pkg::reading_t                digits;

	edge_gate_counter edge_gate_counter_i (
		.clock(clock),
		.reset(reset),
		.signal_in(signal_in),
		.count_valid(count_valid),
		.count(count),
		.credit_return(credit_return)
	);

	dabble_controller dabble_controller_i (
		.clock(clock),
		.reset(reset),
		.count_valid(count_valid),
		.count(count),
		.credit_return(credit_return),
		.cell_clear(cell_clear),
		.cell_shift(cell_shift),
		.serial_bit(serial_bit),
		.convert_done(convert_done)
	);

	assign carry[0] = serial_bit;

	for (genvar k = 0; k < freq_pkg::NUM_DIGITS; k++) begin : g_cell
		bcd_digit_cell bcd_digit_cell_i (
			.clock(clock),
			.reset(reset),
			.cell_clear(cell_clear),
			.cell_shift(cell_shift),
			.carry_in(carry[k]),
			.carry_out(carry[k+1]),
			.digit(digits[k*4 +: 4])
		);
	end

	display_scanner display_scanner_i (
		.clock(clock),
		.reset(reset),
		.convert_done(convert_done),
		.digits(digits),
		.reading(reading),
		.reading_valid(reading_valid),
		.segment(segment),
		.anode(anode)
	);

	// a full scale count fits in eight digits, so nothing leaves the chain
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		cell_shift |-> !carry[freq_pkg::NUM_DIGITS]);

endmodule

`default_nettype wire

// File: rtl/display_scanner.sv
// ======================================================================
// latches each finished bcd reading, presents it on the parallel port
// with a one cycle valid pulse, and multiplexes it onto eight common
// anode digits with the decimal point fixed on one digit
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module display_scanner (
	input  logic               clock,
	input  logic               reset,
	input  logic               convert_done,
	input  freq_pkg::reading_t digits,
	output freq_pkg::reading_t reading,
	output logic               reading_valid,
	output freq_pkg::segment_t segment,
	output freq_pkg::anode_t   anode
);
	freq_pkg::dwell_timer_t dwell;
	freq_pkg::digit_sel_t   digit_sel;
	freq_pkg::bcd_digit_t   shown_digit;
	logic [6:0]             glyph;

	// reading latch
	always_ff @(posedge clock) begin
		if (reset) begin
			reading <= '0;
			reading_valid <= 1'b0;
		end else begin
			reading_valid <= convert_done;
			if (convert_done) begin
				reading <= digits;
			end
		end
	end

	// anode scan, digit 0 first after reset
	always_ff @(posedge clock) begin
		if (reset) begin
			anode <= '0;
			digit_sel <= '0;
			dwell <= '0;
		end else if (anode == '0) begin
			anode <= freq_pkg::anode_t'(1);
			dwell <= '0;
		end else if (dwell == freq_pkg::dwell_timer_t'(freq_pkg::DIGIT_DWELL - 1)) begin
			dwell <= '0;
			anode <= {anode[freq_pkg::NUM_DIGITS-2:0], anode[freq_pkg::NUM_DIGITS-1]};
			if (digit_sel == freq_pkg::digit_sel_t'(freq_pkg::NUM_DIGITS - 1)) begin
				digit_sel <= '0;
			end else begin
				digit_sel <= digit_sel + freq_pkg::digit_sel_t'(1);
			end
		end else begin
			dwell <= dwell + freq_pkg::dwell_timer_t'(1);
		end
	end

	assign shown_digit = reading[digit_sel*4 +: 4];

	// segments g..a
	always_comb begin
		case (shown_digit)
			4'd0: glyph = 7'h3f;
			4'd1: glyph = 7'h06;
			4'd2: glyph = 7'h5b;
			4'd3: glyph = 7'h4f;
			4'd4: glyph = 7'h66;
			4'd5: glyph = 7'h6d;
			4'd6: glyph = 7'h7d;
			4'd7: glyph = 7'h07;
			4'd8: glyph = 7'h7f;
			4'd9: glyph = 7'h6f;
			default: glyph = 7'h00;
		endcase
	end

	// dark until the first anode is driven
	assign segment = (anode == '0) ? '0
		: {glyph, digit_sel == freq_pkg::digit_sel_t'(freq_pkg::DP_DIGIT)};

	a_anode_onehot0: assert property (@(posedge clock) disable iff (reset)
		$onehot0(anode));

	// the lit anode is the digit being decoded
	a_anode_matches_sel: assert property (@(posedge clock) disable iff (reset)
		anode != '0 |-> anode == (freq_pkg::anode_t'(1) << digit_sel));

endmodule

`default_nettype wire

// File: rtl/dabble_controller.sv
// ======================================================================
// serial double dabble control; takes one count, clears the digit
// cells, shifts the count msb first through them, then flags the
// conversion done and returns the credit to the gate counter
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module dabble_controller (
	input  logic             clock,
	input  logic             reset,
	input  logic             count_valid,
	input  freq_pkg::count_t count,
	output logic             credit_return,
	output logic             cell_clear,
	output logic             cell_shift,
	output logic             serial_bit,
	output logic             convert_done
);
	freq_pkg::ctrl_state_t  state;
	freq_pkg::count_t       shift_reg;
	freq_pkg::shift_count_t bit_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= freq_pkg::IDLE;
			cell_clear <= 1'b0;
			cell_shift <= 1'b0;
			bit_count <= '0;
		end else begin
			cell_clear <= 1'b0;
			case (state)
				freq_pkg::IDLE: begin
					if (count_valid) begin
						cell_clear <= 1'b1;
						bit_count <= '0;
						state <= freq_pkg::SHIFT;
					end
				end
				freq_pkg::SHIFT: begin
					// clear cycle, shifting starts on the next one
					if (cell_clear) begin
						cell_shift <= 1'b1;
					end else if (bit_count
						== freq_pkg::shift_count_t'(freq_pkg::COUNT_WIDTH - 1)) begin
						cell_shift <= 1'b0;
						state <= freq_pkg::DONE;
					end else begin
						bit_count <= bit_count + freq_pkg::shift_count_t'(1);
					end
				end
				default: begin
					state <= freq_pkg::IDLE;
				end
			endcase
		end
	end

	// count payload, shifted left once per cell shift
	always_ff @(posedge clock) begin
		if (state == freq_pkg::IDLE && count_valid) begin
			shift_reg <= count;
		end else if (cell_shift) begin
			shift_reg <= shift_reg << 1;
		end
	end

	assign serial_bit = shift_reg[freq_pkg::COUNT_WIDTH-1];

	// done and credit share the single DONE cycle
	assign convert_done = (state == freq_pkg::DONE);
	assign credit_return = (state == freq_pkg::DONE);

	// the one credit keeps a new count from arriving mid conversion
	a_valid_in_idle: assert property (@(posedge clock) disable iff (reset)
		count_valid |-> state == freq_pkg::IDLE);

endmodule

`default_nettype wire

// File: rtl/edge_gate_counter.sv
// ======================================================================
// counts rising edges of an external square wave over a fixed gate of
// system clocks and hands each finished count to the converter, one
// count per credit; without a credit the gate pauses on the held count
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module edge_gate_counter (
	input  logic             clock,
	input  logic             reset,
	input  logic             signal_in,
	output logic             count_valid,
	output freq_pkg::count_t count,
	input  logic             credit_return
);
	// two flop synchronizer plus one for edge detection
	logic sync_meta;
	logic sync_stable;
	logic sync_prev;
	logic rise;

	freq_pkg::gate_timer_t gate_timer;
	freq_pkg::count_t      edge_count;
	freq_pkg::count_t      next_count;
	logic                  gate_end;
	logic                  credit;
	// finished count waiting for a credit
	logic                  holding;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
			sync_prev <= 1'b0;
		end else begin
			sync_meta <= signal_in;
			sync_stable <= sync_meta;
			sync_prev <= sync_stable;
		end
	end

	assign rise = sync_stable & ~sync_prev;

	// saturate at all ones
	assign next_count = (rise && (edge_count != '1)) ? edge_count + freq_pkg::count_t'(1)
		: edge_count;

	// gate runs only while nothing is held
	assign gate_end = !holding
		&& (gate_timer == freq_pkg::gate_timer_t'(freq_pkg::GATE_CYCLES - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			count_valid <= 1'b0;
			gate_timer <= '0;
			edge_count <= '0;
			credit <= 1'b1;
			holding <= 1'b0;
		end else begin
			count_valid <= 1'b0;
			if (credit_return) begin
				credit <= 1'b1;
			end
			if (holding) begin
				// credit came back, send the kept count and restart
				if (credit_return) begin
					count_valid <= 1'b1;
					credit <= 1'b0;
					holding <= 1'b0;
					gate_timer <= '0;
					edge_count <= '0;
				end
			end else if (gate_end) begin
				gate_timer <= '0;
				edge_count <= '0;
				if (credit || credit_return) begin
					count_valid <= 1'b1;
					credit <= 1'b0;
				end else begin
					holding <= 1'b1;
				end
			end else begin
				gate_timer <= gate_timer + freq_pkg::gate_timer_t'(1);
				edge_count <= next_count;
			end
		end
	end

	// result register, loaded once per gate
	always_ff @(posedge clock) begin
		if (gate_end) begin
			count <= next_count;
		end
	end

	// after a count leaves, the next one waits for the credit to come back
	a_valid_needs_credit: assert property (@(posedge clock) disable iff (reset)
		count_valid |=> (!count_valid throughout credit_return [->1]));

endmodule

`default_nettype wire

// File: rtl/bcd_digit_cell.sv
// ======================================================================
// one decimal digit of the serial double dabble chain; cells are
// chained lsb digit first, carry_out of one feeding carry_in of the next
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module bcd_digit_cell (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 cell_clear,
	input  logic                 cell_shift,
	input  logic                 carry_in,
	output logic                 carry_out,
	output freq_pkg::bcd_digit_t digit
);
	freq_pkg::bcd_digit_t adjusted;

	// add three before the shift when the digit would pass nine
	assign adjusted = (digit >= 4'd5) ? digit + 4'd3 : digit;
	// adjusted msb moves on to the next digit
	assign carry_out = adjusted[3];

	always_ff @(posedge clock) begin
		if (reset || cell_clear) begin
			digit <= '0;
		end else if (cell_shift) begin
			digit <= {adjusted[2:0], carry_in};
		end
	end

	a_digit_decimal: assert property (@(posedge clock) disable iff (reset)
		digit <= 4'd9);

endmodule

`default_nettype wire

// File: rtl/freq_pkg.sv
// ======================================================================
// shared widths, timing constants and types of the frequency counter
// with its eight-digit seven-segment display; design files and the
// testbench refer to these by scoped name
// ======================================================================
`default_nettype none

package freq_pkg;

	// measured count
	localparam int COUNT_WIDTH = 24;
	typedef logic [COUNT_WIDTH-1:0] count_t;

	// bcd reading, digit 0 in the low nibble
	localparam int NUM_DIGITS = 8;
	typedef logic [3:0] bcd_digit_t;
	typedef logic [NUM_DIGITS*4-1:0] reading_t;

	// gate length in system clocks
	localparam int GATE_CYCLES = 1000;
	localparam int GATE_WIDTH = $clog2(GATE_CYCLES);
	typedef logic [GATE_WIDTH-1:0] gate_timer_t;

	// shift counter for the serial conversion
	localparam int SHIFT_WIDTH = $clog2(COUNT_WIDTH);
	typedef logic [SHIFT_WIDTH-1:0] shift_count_t;

	// display scan
	localparam int DIGIT_DWELL = 16;
	localparam int DWELL_WIDTH = $clog2(DIGIT_DWELL);
	typedef logic [DWELL_WIDTH-1:0] dwell_timer_t;
	localparam int DIGIT_SEL_WIDTH = $clog2(NUM_DIGITS);
	typedef logic [DIGIT_SEL_WIDTH-1:0] digit_sel_t;
	// one hertz format, point after the sixth digit
	localparam int DP_DIGIT = 6;

	// segments g,f,e,d,c,b,a,dp and anodes, all active high
	typedef logic [7:0] segment_t;
	typedef logic [NUM_DIGITS-1:0] anode_t;

	// dabble controller states
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} ctrl_state_t;

endpackage

`default_nettype wire
